// File: source/rv_ex_pkg.sv
package rv_ex_pkg;

  // Datapath width
  localparam int XLEN = 32;
  // Shift amount and divider step counter width
  localparam int LOG2_XLEN = $clog2(XLEN);

  // Canonical NOP, addi x0, x0, 0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // M extension funct3, bit 2 marks the divide class
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;
  localparam logic [2:0] F3_DIV    = 3'b100;
  localparam logic [2:0] F3_DIVU   = 3'b101;
  localparam logic [2:0] F3_REM    = 3'b110;
  localparam logic [2:0] F3_REMU   = 3'b111;

  // Zicntr read-only counters
  localparam logic [11:0] CSR_CYCLE    = 12'hC00;
  localparam logic [11:0] CSR_INSTRET  = 12'hC02;
  localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
  localparam logic [11:0] CSR_INSTRETH = 12'hC82;

  // Instruction class seen by the ALU decoder
  localparam logic [1:0] ALU_INSTR_ADD    = 2'b00;
  localparam logic [1:0] ALU_INSTR_BRANCH = 2'b01;
  localparam logic [1:0] ALU_INSTR_OP     = 2'b10;

  // ALU operand A sources
  localparam logic [1:0] ALU_A_RS1  = 2'd0;
  localparam logic [1:0] ALU_A_ZERO = 2'd1;
  localparam logic [1:0] ALU_A_PC   = 2'd2;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Writeback source for MEM and WB
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_LOAD = 3'd1,
    RES_PC4  = 3'd2,
    RES_CSR  = 3'd3,
    RES_M    = 3'd4
  } res_src_e;

  // Control from ID
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] alu_a_src;
    // 0 selects rs2, 1 selects imm
    logic       alu_b_src;
    logic [1:0] alu_instr;
    res_src_e   res_src;
    logic       is_branch;
    logic       is_jump;
    // 0 is pc + imm, 1 is JALR
    logic       jb_target_src;
    logic       is_mc;
  } ex_ctrl_t;

  // Operands and fields from ID
  typedef struct packed {
    logic [31:0]     instr;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
  } ex_data_t;

  // Register file write port at WB
  typedef struct packed {
    logic [4:0]      rd;
    logic            reg_write;
    logic [XLEN-1:0] data;
  } wb_fwd_t;

  // EX/MEM pipeline register
  typedef struct packed {
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    res_src_e        res_src;
    logic [31:0]     instr;
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jb_target;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] m_result;
  } ex_mem_t;

endpackage

// File: source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
  import rv_ex_pkg::*;
(
  input  logic [1:0]      alu_instr,
  input  logic [2:0]      funct3,
  input  logic            funct7_b5,
  input  logic            op_b5,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic [XLEN-1:0] result
);

  alu_op_e              op;
  logic [LOG2_XLEN-1:0] shamt;

  // Only the low bits of b shift
  assign shamt = b[LOG2_XLEN-1:0];

  // Operation decode
  always_comb begin
    op = ALU_ADD;
    case (alu_instr)
      // Loads, stores, jumps, lui, auipc
      ALU_INSTR_ADD: op = ALU_ADD;
      // Branches compare by subtraction
      ALU_INSTR_BRANCH: op = ALU_SUB;
      ALU_INSTR_OP: begin
        case (funct3)
          // addi has no sub form, so op_b5 must flag R-type
          3'b000: op = (funct7_b5 && op_b5) ? ALU_SUB : ALU_ADD;
          3'b001: op = ALU_SLL;
          3'b010: op = ALU_SLT;
          3'b011: op = ALU_SLTU;
          3'b100: op = ALU_XOR;
          // srai keeps funct7 bit 5 in its immediate
          3'b101: op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          default: op = ALU_ADD;
        endcase
      end
      default: op = ALU_ADD;
    endcase
  end

  // Evaluate
  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result = XLEN'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

// File: source/rv_forward.sv
`timescale 1ns/1ps

module rv_forward
  import rv_ex_pkg::*;
(
  input  ex_data_t        data,
  input  ex_mem_t         mem,
  input  logic [XLEN-1:0] result_mem,
  input  logic [XLEN-1:0] load_data_mem,
  input  wb_fwd_t         wb,
  output logic [XLEN-1:0] fwd_rs1,
  output logic [XLEN-1:0] fwd_rs2
);

  logic [XLEN-1:0] mem_value;

  // Loads only have their data at MEM
  assign mem_value = (mem.res_src == RES_LOAD) ? load_data_mem : result_mem;

  // Priority pick for one source register
  function automatic logic [XLEN-1:0] pick(
    input logic [4:0]      rs,
    input logic [XLEN-1:0] rf_value
  );
    logic [XLEN-1:0] value;
    value = rf_value;
    // x0 never forwards
    if (rs != 5'd0) begin
      // Younger MEM result wins over WB
      if (mem.reg_write && (mem.rd == rs)) begin
        value = mem_value;
      end else if (wb.reg_write && (wb.rd == rs)) begin
        value = wb.data;
      end
    end
    return value;
  endfunction

  always_comb begin
    fwd_rs1 = pick(data.rs1, data.rs1_data);
    fwd_rs2 = pick(data.rs2, data.rs2_data);
  end

endmodule

// File: source/rv_branch_unit.sv
`timescale 1ns/1ps

module rv_branch_unit
  import rv_ex_pkg::*;
(
  input  ex_ctrl_t        ctrl,
  input  logic [2:0]      funct3,
  input  logic [XLEN-1:0] rs1,
  input  logic [XLEN-1:0] rs2,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] imm,
  input  logic [XLEN-1:0] alu_result,
  output logic            pc_sel,
  output logic [XLEN-1:0] target
);

  logic eq;
  logic lt;
  logic ltu;
  logic taken;

  assign eq  = (rs1 == rs2);
  assign lt  = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  // Condition by funct3
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt;
      F3_BGE:  taken = !lt;
      F3_BLTU: taken = ltu;
      F3_BGEU: taken = !ltu;
      // Reserved encodings never branch
      default: taken = 1'b0;
    endcase
  end

  // JALR goes through the ALU as rs1 + imm
  // Bit 0 cleared for JALR only
  always_comb begin
    if (ctrl.jb_target_src) begin
      target = {alu_result[XLEN-1:1], 1'b0};
    end else begin
      // JAL and branches use their own adder
      target = pc + imm;
    end
  end

  // No predictor, so every jump and taken branch redirects
  assign pc_sel = ctrl.is_jump || (ctrl.is_branch && taken);

endmodule

// File: source/rv_muldiv.sv
`timescale 1ns/1ps

module rv_muldiv
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  logic [2:0]      op,
  input  logic [XLEN-1:0] rs1,
  input  logic [XLEN-1:0] rs2,
  output logic            busy,
  output logic [XLEN-1:0] result
);

  logic                     a_sx;
  logic                     b_sx;
  logic signed [2*XLEN+1:0] prod;
  logic [XLEN-1:0]          mul_result;
  logic                     div_signed;
  logic                     a_neg;
  logic                     b_neg;
  logic [XLEN-1:0]          a_mag;
  logic [XLEN-1:0]          b_mag;
  logic [XLEN-1:0]          quo;
  logic [XLEN-1:0]          rem;
  logic [XLEN-1:0]          dvsr;
  logic [LOG2_XLEN-1:0]     cnt;
  logic                     neg_q;
  logic                     neg_r;
  logic                     rem_sel;
  logic [XLEN:0]            rem_shift;
  logic                     rem_ge;
  logic [XLEN-1:0]          div_result;

  // Multiply, one extra bit per operand
  // carries signed or unsigned
  assign a_sx = ((op == F3_MULH) || (op == F3_MULHSU)) && rs1[XLEN-1];
  assign b_sx = (op == F3_MULH) && rs2[XLEN-1];
  assign prod = $signed({a_sx, rs1}) * $signed({b_sx, rs2});
  assign mul_result = (op == F3_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

  // DIV and REM are signed, funct3 bit 0 clear
  assign div_signed = !op[0];
  assign a_neg      = div_signed && rs1[XLEN-1];
  assign b_neg      = div_signed && rs2[XLEN-1];
  assign a_mag      = a_neg ? -rs1 : rs1;
  assign b_mag      = b_neg ? -rs2 : rs2;

  // Next dividend bit shifts into the partial remainder
  assign rem_shift = {rem, quo[XLEN-1]};
  assign rem_ge    = (rem_shift >= {1'b0, dvsr});

  // Step control, XLEN busy cycles after start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == LOG2_XLEN'(XLEN - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  // Restoring divider, quotient bits replace dividend bits in quo
  always_ff @(posedge clk) begin
    if (start) begin
      quo     <= a_mag;
      rem     <= '0;
      dvsr    <= b_mag;
      // Divide by zero keeps an all ones quotient unsigned
      neg_q   <= (a_neg ^ b_neg) && (rs2 != '0);
      // Remainder takes the dividend's sign
      neg_r   <= a_neg;
      rem_sel <= op[1];
    end else if (busy) begin
      if (rem_ge) begin
        rem <= XLEN'(rem_shift - {1'b0, dvsr});
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_shift[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  // Signs applied at the end
  // MIN / -1 wraps back to MIN with zero remainder
  always_comb begin
    if (rem_sel) begin
      div_result = neg_r ? -rem : rem;
    end else begin
      div_result = neg_q ? -quo : quo;
    end
  end

  assign result = op[2] ? div_result : mul_result;

endmodule

// File: source/rv_counters.sv
`timescale 1ns/1ps

module rv_counters
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instret_inc,
  input  logic [11:0]     addr,
  output logic [XLEN-1:0] rdata
);

  // Both counters are 64 bits on RV32
  logic [2*XLEN-1:0] cycle_cnt;
  logic [2*XLEN-1:0] instret_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cycle_cnt   <= '0;
      instret_cnt <= '0;
    end else begin
      // Free running
      cycle_cnt <= cycle_cnt + 1'b1;
      if (instret_inc) begin
        instret_cnt <= instret_cnt + 1'b1;
      end
    end
  end

  // Read decode, h variants give the upper half
  always_comb begin
    case (addr)
      CSR_CYCLE:    rdata = cycle_cnt[XLEN-1:0];
      CSR_CYCLEH:   rdata = cycle_cnt[2*XLEN-1:XLEN];
      CSR_INSTRET:  rdata = instret_cnt[XLEN-1:0];
      CSR_INSTRETH: rdata = instret_cnt[2*XLEN-1:XLEN];
      default:      rdata = '0;
    endcase
  end

endmodule

// File: source/rv_stage_ex.sv
`timescale 1ns/1ps

module rv_stage_ex
  import rv_ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ex_mem_stall,
  input  ex_ctrl_t        ctrl,
  input  ex_data_t        data,
  input  logic [XLEN-1:0] result_mem,
  input  logic [XLEN-1:0] load_data_mem,
  input  wb_fwd_t         wb,
  input  logic            instr_retired,
  output logic            pc_sel,
  output logic [XLEN-1:0] pc_redirect_target,
  output ex_mem_t         mem,
  output logic            is_csr,
  output logic            op_active
);

  typedef enum logic {
    MC_IDLE,
    MC_EXEC
  } mc_state_e;

  logic [XLEN-1:0] fwd_rs1;
  logic [XLEN-1:0] fwd_rs2;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] m_result;
  logic            m_busy;
  logic            op_en;
  logic [XLEN-1:0] csr_rdata;
  mc_state_e       mc_state;
  mc_state_e       mc_state_next;
  ex_mem_t         mem_d;

  // Operands from MEM, WB or the register file
  rv_forward u_forward (
    .data          (data),
    .mem           (mem),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .wb            (wb),
    .fwd_rs1       (fwd_rs1),
    .fwd_rs2       (fwd_rs2)
  );

  // Operand A: auipc uses pc, lui uses zero
  always_comb begin
    case (ctrl.alu_a_src)
      ALU_A_ZERO: alu_a = '0;
      ALU_A_PC:   alu_a = data.pc;
      default:    alu_a = fwd_rs1;
    endcase
  end

  // Operand B
  assign alu_b = ctrl.alu_b_src ? data.imm : fwd_rs2;

  // instr bit 5 separates OP from OP-IMM
  rv_alu u_alu (
    .alu_instr (ctrl.alu_instr),
    .funct3    (data.funct3),
    .funct7_b5 (data.funct7[5]),
    .op_b5     (data.instr[5]),
    .a         (alu_a),
    .b         (alu_b),
    .result    (alu_result)
  );

  // Compare on the forwarded registers
  rv_branch_unit u_branch (
    .ctrl       (ctrl),
    .funct3     (data.funct3),
    .rs1        (fwd_rs1),
    .rs2        (fwd_rs2),
    .pc         (data.pc),
    .imm        (data.imm),
    .alu_result (alu_result),
    .pc_sel     (pc_sel),
    .target     (pc_redirect_target)
  );

  rv_muldiv u_muldiv (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (op_en),
    .op     (data.funct3),
    .rs1    (fwd_rs1),
    .rs2    (fwd_rs2),
    .busy   (m_busy),
    .result (m_result)
  );

  // CSR address sits in the I-type immediate
  rv_counters u_counters (
    .clk         (clk),
    .rst_n       (rst_n),
    .instret_inc (instr_retired),
    .addr        (data.imm[11:0]),
    .rdata       (csr_rdata)
  );

  assign is_csr = (ctrl.res_src == RES_CSR);

  // Multi-cycle control
  // Start cycle and busy cycles hold the instruction in EX
  always_comb begin
    mc_state_next = mc_state;
    op_en         = 1'b0;
    op_active     = 1'b0;
    case (mc_state)
      MC_IDLE: begin
        if (ctrl.is_mc) begin
          op_en         = 1'b1;
          op_active     = 1'b1;
          mc_state_next = MC_EXEC;
        end
      end
      MC_EXEC: begin
        // Result valid once busy drops
        if (m_busy) begin
          op_active = 1'b1;
        end else begin
          mc_state_next = MC_IDLE;
        end
      end
      default: mc_state_next = MC_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mc_state <= MC_IDLE;
    end else begin
      mc_state <= mc_state_next;
    end
  end

  // Next EX/MEM contents
  always_comb begin
    mem_d.reg_write  = ctrl.reg_write;
    mem_d.mem_read   = ctrl.mem_read;
    mem_d.mem_write  = ctrl.mem_write;
    mem_d.res_src    = ctrl.res_src;
    mem_d.instr      = data.instr;
    mem_d.rd         = data.rd;
    mem_d.rs2        = data.rs2;
    mem_d.funct3     = data.funct3;
    mem_d.alu_result = alu_result;
    // Store data needs the forwarded value
    mem_d.rs2_data   = fwd_rs2;
    mem_d.pc_plus4   = data.pc_plus4;
    mem_d.jb_target  = pc_redirect_target;
    mem_d.csr_rdata  = csr_rdata;
    mem_d.m_result   = m_result;
  end

  // EX/MEM register, holds on stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem       <= '0;
      mem.instr <= I_NOP;
    end else if (!ex_mem_stall) begin
      mem <= mem_d;
    end
  end

endmodule

// File: verif/rv_stage_ex_tb.sv
`timescale 1ns/1ps

module rv_stage_ex_tb
  import rv_ex_pkg::*;
();

  localparam int NUM_OPS      = 400;
  localparam int RESET_CYCLES = 10;
  // Budget assumes a divide on every operation
  localparam longint WATCHDOG_NS = longint'(NUM_OPS * (XLEN + 4) + 20) * 100;

  logic            clk;
  logic            rst_n;
  logic            ex_mem_stall;
  ex_ctrl_t        ctrl;
  ex_data_t        data;
  logic [XLEN-1:0] result_mem;
  logic [XLEN-1:0] load_data_mem;
  wb_fwd_t         wb;
  logic            instr_retired;
  logic            pc_sel;
  logic [XLEN-1:0] pc_redirect_target;
  ex_mem_t         mem;
  logic            is_csr;
  logic            op_active;

  integer seed;

  // Model copy of the registered MEM fields used for forwarding
  logic [4:0]        m_rd;
  logic              m_rw;
  res_src_e          m_res;
  logic [2*XLEN-1:0] cycle_model;
  logic [2*XLEN-1:0] instret_model;
  ex_mem_t           exp_mem;
  ex_mem_t           last_mem;
  logic              last_has_m;
  logic [XLEN-1:0]   exp_f1;
  logic [XLEN-1:0]   exp_f2;
  logic [XLEN-1:0]   exp_target;
  logic [XLEN-1:0]   div_exp;
  logic              exp_pc_sel;

  rv_stage_ex dut0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_mem_stall       (ex_mem_stall),
    .ctrl               (ctrl),
    .data               (data),
    .result_mem         (result_mem),
    .load_data_mem      (load_data_mem),
    .wb                 (wb),
    .instr_retired      (instr_retired),
    .pc_sel             (pc_sel),
    .pc_redirect_target (pc_redirect_target),
    .mem                (mem),
    .is_csr             (is_csr),
    .op_active          (op_active)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Cycle and instret counters as seen at each rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_model   <= '0;
      instret_model <= '0;
    end else begin
      cycle_model <= cycle_model + 1;
      if (instr_retired) begin
        instret_model <= instret_model + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the operations did not complete within the expected time");
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Value check failed");
    end
  endtask

  // MEM wins over WB and x0 never forwards
  function automatic logic [XLEN-1:0] fwd_model(input logic [4:0] rs,
                                                input logic [XLEN-1:0] rf);
    if (rs == 5'd0) return rf;
    if (m_rw && (m_rd == rs)) return (m_res == RES_LOAD) ? load_data_mem : result_mem;
    if (wb.reg_write && (wb.rd == rs)) return wb.data;
    return rf;
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input logic [1:0] cls, input logic [2:0] f3,
                                                input logic f7b5, input logic is_r,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [LOG2_XLEN-1:0] sh;
    logic [XLEN-1:0]      res;
    sh = b[LOG2_XLEN-1:0];
    res = a + b;
    if (cls == ALU_INSTR_BRANCH) begin
      res = a - b;
    end else if (cls == ALU_INSTR_OP) begin
      case (f3)
        3'b000: res = (f7b5 && is_r) ? a - b : a + b;
        3'b001: res = a << sh;
        3'b010: res = ($signed(a) < $signed(b)) ? 1 : 0;
        3'b011: res = (a < b) ? 1 : 0;
        3'b100: res = a ^ b;
        3'b101: res = f7b5 ? $unsigned($signed(a) >>> sh) : a >> sh;
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end
    return res;
  endfunction

  function automatic logic taken_model(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Extended operands give every product modulo 2^64
  function automatic logic [XLEN-1:0] mul_model(input logic [2:0] f3,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] p;
    ea = {{XLEN{a[XLEN-1] && (f3 == F3_MULH || f3 == F3_MULHSU)}}, a};
    eb = {{XLEN{b[XLEN-1] && (f3 == F3_MULH)}}, b};
    p = ea * eb;
    return (f3 == F3_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
  endfunction

  function automatic logic [XLEN-1:0] div_model(input logic [2:0] f3,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic            sgn;
    logic            is_rem;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    sgn = (f3 == F3_DIV) || (f3 == F3_REM);
    is_rem = (f3 == F3_REM) || (f3 == F3_REMU);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1)) begin
      q = a;
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return is_rem ? r : q;
  endfunction

  function automatic logic [XLEN-1:0] csr_model(input logic [11:0] addr);
    case (addr)
      CSR_CYCLE:    return cycle_model[XLEN-1:0];
      CSR_CYCLEH:   return cycle_model[2*XLEN-1:XLEN];
      CSR_INSTRET:  return instret_model[XLEN-1:0];
      CSR_INSTRETH: return instret_model[2*XLEN-1:XLEN];
      default:      return '0;
    endcase
  endfunction

  // Source register hitting MEM, WB, both, x0 or anything
  task automatic pick_src(output logic [4:0] r);
    logic [31:0] x;
    x = rnd();
    case (x[2:0])
      3'd0: r = m_rd;
      3'd1: r = wb.rd;
      3'd2: begin
        wb.rd = m_rd;
        r = m_rd;
      end
      3'd3: r = 5'd0;
      default: r = x[12:8];
    endcase
  endtask

  // Register that neither MEM nor WB overrides
  task automatic free_reg(input logic [4:0] avoid, output logic [4:0] r);
    logic [31:0] x;
    x = rnd();
    r = x[4:0];
    while ((r == 5'd0) || (r == avoid) || (m_rw && (r == m_rd)) ||
           (wb.reg_write && (r == wb.rd))) begin
      r = r + 5'd1;
    end
  endtask

  task automatic gen_op(input logic [3:0] kind);
    logic [31:0] x;
    logic [31:0] y;
    logic [11:0] imm12;
    logic [6:0]  opc;
    x = rnd();
    y = rnd();
    ctrl = '0;
    data = '0;
    ex_mem_stall = 1'b0;
    wb.rd = y[4:0];
    wb.reg_write = (y[6:5] != 2'b00);
    wb.data = rnd();
    result_mem = rnd();
    load_data_mem = rnd();
    instr_retired = y[7];
    data.rd = y[12:8];
    pick_src(data.rs1);
    pick_src(data.rs2);
    data.rs1_data = rnd();
    data.rs2_data = rnd();
    data.pc = {y[31:14], 2'b00} << 2;
    data.pc_plus4 = data.pc + 4;
    imm12 = x[31:20];
    data.imm = {{(XLEN-12){imm12[11]}}, imm12};
    data.funct3 = x[2:0];
    ctrl.reg_write = 1'b1;
    ctrl.alu_instr = ALU_INSTR_ADD;
    opc = OPC_OP;
    case (kind)
      4'd2, 4'd3: begin
        ctrl.alu_instr = ALU_INSTR_OP;
        ctrl.alu_b_src = 1'b1;
        opc = OPC_OP_IMM;
        // Shift immediates keep only the shamt and the srai flag
        if (x[2:0] == 3'b001) imm12[11:5] = 7'b0;
        if (x[2:0] == 3'b101) imm12[11:5] = {1'b0, x[3], 5'b0};
        data.imm = {{(XLEN-12){imm12[11]}}, imm12};
        data.funct7 = imm12[11:5];
        data.rs2 = imm12[4:0];
      end
      4'd4: begin
        // lui or auipc
        ctrl.alu_b_src = 1'b1;
        ctrl.alu_a_src = x[3] ? ALU_A_PC : ALU_A_ZERO;
        opc = x[3] ? 7'b001_0111 : 7'b011_0111;
        data.imm = {x[31:12], 12'b0};
      end
      4'd5: begin
        ctrl.alu_b_src = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.res_src = RES_LOAD;
        opc = OPC_LOAD;
      end
      4'd6: begin
        ctrl.alu_b_src = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.reg_write = 1'b0;
        opc = OPC_STORE;
      end
      4'd7, 4'd8: begin
        ctrl.is_branch = 1'b1;
        ctrl.reg_write = 1'b0;
        ctrl.alu_instr = ALU_INSTR_BRANCH;
        opc = OPC_BRANCH;
        data.imm = {{(XLEN-13){x[31]}}, x[31:20], 1'b0};
        // Same register makes equal operands likely
        if (x[4:3] == 2'b00) data.rs2 = data.rs1;
      end
      4'd9: begin
        ctrl.is_jump = 1'b1;
        ctrl.res_src = RES_PC4;
        ctrl.alu_b_src = 1'b1;
        if (x[3]) begin
          ctrl.jb_target_src = 1'b1;
          opc = OPC_JALR;
        end else begin
          ctrl.alu_a_src = ALU_A_PC;
          opc = OPC_JAL;
          data.imm = {{(XLEN-21){x[31]}}, x[31:12], 1'b0};
        end
      end
      4'd10, 4'd11, 4'd12: begin
        ctrl.alu_instr = ALU_INSTR_OP;
        ctrl.res_src = RES_M;
        ctrl.is_mc = x[2];
        data.funct7 = 7'b000_0001;
        // Corner operands for the divider
        if (x[2] && (x[5:4] == 2'd0)) begin
          data.rs2 = 5'd0;
        end else if (x[2] && (x[5:4] == 2'd1)) begin
          free_reg(5'd0, data.rs1);
          free_reg(data.rs1, data.rs2);
          data.rs1_data = {1'b1, {(XLEN-1){1'b0}}};
          data.rs2_data = '1;
        end
      end
      4'd13, 4'd14: begin
        ctrl.res_src = RES_CSR;
        ctrl.alu_b_src = 1'b1;
        opc = OPC_SYSTEM;
        data.funct3 = 3'b010;
        data.rs1 = 5'd0;
        case (x[4:3])
          2'd0: imm12 = CSR_CYCLE;
          2'd1: imm12 = CSR_CYCLEH;
          2'd2: imm12 = CSR_INSTRET;
          default: imm12 = CSR_INSTRETH;
        endcase
        // Now and then an address with no counter
        if (x[6:5] == 2'b00) imm12 = x[31:20];
        data.imm = {{(XLEN-12){1'b0}}, imm12};
      end
      default: begin
        // Register-register ALU
        ctrl.alu_instr = ALU_INSTR_OP;
        if ((x[2:0] == 3'b000) || (x[2:0] == 3'b101)) data.funct7 = {1'b0, x[3], 5'b0};
      end
    endcase
    // Register file reads x0 as zero
    if (data.rs1 == 5'd0) data.rs1_data = '0;
    if (data.rs2 == 5'd0) data.rs2_data = '0;
    data.instr = {data.funct7, data.rs2, data.rs1, data.funct3, data.rd, opc};
    if (!ctrl.is_mc && (y[13:11] == 3'd0)) ex_mem_stall = 1'b1;
  endtask

  task automatic compute_expected();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu;
    exp_f1 = fwd_model(data.rs1, data.rs1_data);
    exp_f2 = fwd_model(data.rs2, data.rs2_data);
    case (ctrl.alu_a_src)
      ALU_A_ZERO: a = '0;
      ALU_A_PC:   a = data.pc;
      default:    a = exp_f1;
    endcase
    b = ctrl.alu_b_src ? data.imm : exp_f2;
    alu = alu_model(ctrl.alu_instr, data.funct3, data.funct7[5], data.instr[5], a, b);
    exp_target = ctrl.jb_target_src ? {alu[XLEN-1:1], 1'b0} : data.pc + data.imm;
    exp_pc_sel = ctrl.is_jump || (ctrl.is_branch && taken_model(data.funct3, exp_f1, exp_f2));
    exp_mem.reg_write = ctrl.reg_write;
    exp_mem.mem_read = ctrl.mem_read;
    exp_mem.mem_write = ctrl.mem_write;
    exp_mem.res_src = ctrl.res_src;
    exp_mem.instr = data.instr;
    exp_mem.rd = data.rd;
    exp_mem.rs2 = data.rs2;
    exp_mem.funct3 = data.funct3;
    exp_mem.alu_result = alu;
    exp_mem.rs2_data = exp_f2;
    exp_mem.pc_plus4 = data.pc_plus4;
    exp_mem.jb_target = exp_target;
    exp_mem.csr_rdata = csr_model(data.imm[11:0]);
    exp_mem.m_result = data.funct3[2] ? div_exp : mul_model(data.funct3, exp_f1, exp_f2);
  endtask

  task automatic check_mem(input ex_mem_t exp, input logic with_m);
    check_value("mem.reg_write", mem.reg_write, exp.reg_write);
    check_value("mem.mem_read", mem.mem_read, exp.mem_read);
    check_value("mem.mem_write", mem.mem_write, exp.mem_write);
    check_value("mem.res_src", mem.res_src, exp.res_src);
    check_value("mem.instr", mem.instr, exp.instr);
    check_value("mem.rd", mem.rd, exp.rd);
    check_value("mem.rs2", mem.rs2, exp.rs2);
    check_value("mem.funct3", mem.funct3, exp.funct3);
    check_value("mem.alu_result", mem.alu_result, exp.alu_result);
    check_value("mem.rs2_data", mem.rs2_data, exp.rs2_data);
    check_value("mem.pc_plus4", mem.pc_plus4, exp.pc_plus4);
    check_value("mem.jb_target", mem.jb_target, exp.jb_target);
    check_value("mem.csr_rdata", mem.csr_rdata, exp.csr_rdata);
    if (with_m) check_value("mem.m_result", mem.m_result, exp.m_result);
  endtask

  // Register capture moves the forwarding source along
  task automatic track_mem();
    m_rd = data.rd;
    m_rw = ctrl.reg_write;
    m_res = ctrl.res_src;
  endtask

  // Starts and ends just after a falling edge
  task automatic run_op();
    int active;
    #10;
    compute_expected();
    // Only the divide class runs over several cycles
    check_value("op_active", op_active, (ctrl.res_src == RES_M) && data.funct3[2]);
    if (ctrl.is_mc) begin
      // Divider latches the start cycle operands
      div_exp = div_model(data.funct3, exp_f1, exp_f2);
      active = 0;
      while (op_active) begin
        @(posedge clk);
        #1;
        track_mem();
        @(negedge clk);
        #10;
        active++;
      end
      check_value("op_active cycles", active, XLEN + 1);
      compute_expected();
    end
    check_value("pc_sel", pc_sel, exp_pc_sel);
    check_value("pc_redirect_target", pc_redirect_target, exp_target);
    // CSR reads are the SYSTEM opcode here
    check_value("is_csr", is_csr, data.instr[6:0] == OPC_SYSTEM);
    @(posedge clk);
    #1;
    if (ex_mem_stall) begin
      check_mem(last_mem, last_has_m);
    end else begin
      check_mem(exp_mem, ctrl.res_src == RES_M);
      last_mem = exp_mem;
      last_has_m = (ctrl.res_src == RES_M);
      track_mem();
    end
    @(negedge clk);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    ex_mem_stall = 1'b0;
    ctrl = '0;
    data = '0;
    result_mem = '0;
    load_data_mem = '0;
    wb = '0;
    instr_retired = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    exp_mem = '0;
    exp_mem.instr = 32'h0000_0013;
    check_mem(exp_mem, 1'b1);
    check_value("op_active", op_active, 1'b0);
    check_value("pc_sel", pc_sel, 1'b0);
    check_value("muldiv busy", dut0.u_muldiv.busy, 1'b0);
    rst_n = 1'b1;
    m_rd = 5'd0;
    m_rw = 1'b0;
    m_res = RES_ALU;
    last_mem = exp_mem;
    last_has_m = 1'b1;
  endtask

  initial begin
    logic [31:0] r;
    seed = 32'h240d;
    div_exp = '0;
    apply_reset();
    for (int i = 0; i < NUM_OPS; i++) begin
      // Second reset in the middle of the run
      if (i == NUM_OPS / 2) apply_reset();
      r = rnd();
      gen_op(r[3:0]);
      run_op();
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: flist.f
source/rv_ex_pkg.sv
source/rv_alu.sv
source/rv_forward.sv
source/rv_branch_unit.sv
source/rv_muldiv.sv
source/rv_counters.sv
source/rv_stage_ex.sv
verif/rv_stage_ex_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the EX stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rv_stage_ex_tb \
  -f flist.f -Mdir obj_dir -o sim > build.log 2>&1 || { echo "Build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1

grep -qx "Finished with no errors" sim.log && echo "Simulation passed" || {
  echo "Simulation failed, see sim.log"
  exit 1
}
